//--- Makefile
VERILATOR ?= verilator
TOP       ?= fifo_32_8_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= All tests passed!

SIM_EXE = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_EXE))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qF "$(PASS_MSG)"; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)

//--- build.f
source/fifo_pkg.sv
source/updown_counter.sv
source/fifo_ram.sv
source/fifo_control.sv
source/fifo_32_8.sv
sim/fifo_32_8_checker.sv
sim/fifo_32_8_tb.sv

//--- sim/fifo_32_8_checker.sv
`timescale 1ns/1ps

module fifo_control_checker (
	input  logic                  CLK,
	input  logic                  RESET_N,
	input  fifo_pkg::fifo_state_t state,
	input  fifo_pkg::count_t      use_dw,
	input  logic                  f_full_n,
	input  logic                  f_empty_n,
	input  logic                  count_en,
	input  logic                  count_up,
	input  logic                  bypass,
	input  logic                  wr_en
);

	import fifo_pkg::*;

	// Flags follow the occupancy count and so are never low together
	assert property (@(posedge CLK) disable iff (!RESET_N)
		(f_empty_n == (use_dw != '0)) && (f_full_n == (use_dw != count_t'(FIFO_DEPTH))))
		else $error("f_full_n or f_empty_n disagrees with use_dw");

	// No count increment once all entries are taken
	assert property (@(posedge CLK) disable iff (!RESET_N)
		!(count_en && count_up && (state == FULL)))
		else $error("occupancy counts up in state FULL");

	// Pass-through must leave the RAM alone
	assert property (@(posedge CLK) disable iff (!RESET_N) !(bypass && wr_en))
		else $error("bypass and wr_en are high together");

endmodule

bind fifo_control fifo_control_checker control_checker (
	.CLK       (CLK),
	.RESET_N   (RESET_N),
	.state     (state),
	.use_dw    (use_dw),
	.f_full_n  (f_full_n),
	.f_empty_n (f_empty_n),
	.count_en  (count_en),
	.count_up  (count_up),
	.bypass    (bypass),
	.wr_en     (wr_en)
);

//--- sim/fifo_32_8_tb.sv
`timescale 1ns/1ps

module fifo_32_8_tb;

	import fifo_pkg::*;

	// Reset and tests take about 200 cycles, the rest is margin
	localparam int  MAX_CYCLES  = 400;
	localparam time DRIVE_DELAY = 10ns;

	logic   CLK;
	logic   RESET_N;
	data_t  data_in;
	logic   read;
	logic   write;
	logic   clear_n;
	data_t  data_out;
	logic   f_full_n;
	logic   f_empty_n;
	count_t use_dw;

	// Reference contents and the word expected on data_out
	data_t model_q[$];
	data_t exp_data;

	int error_count;
	int tests_passed;
	int tests_failed;
	int cycle_count;

	fifo_32_8 DUT (
		.CLK       (CLK),
		.RESET_N   (RESET_N),
		.data_in   (data_in),
		.read      (read),
		.write     (write),
		.clear_n   (clear_n),
		.data_out  (data_out),
		.f_full_n  (f_full_n),
		.f_empty_n (f_empty_n),
		.use_dw    (use_dw)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES) begin
			@(posedge CLK);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
		$display("Test failures found");
		$finish;
	end

	task automatic compare_data(input string name, input data_t expected, input data_t actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected 0x%h, got 0x%h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic compare_count(input count_t expected, input count_t actual);
		if (actual !== expected) begin
			$display("ERROR use_dw: expected 0x%h, got 0x%h", expected, actual);
			error_count++;
		end
	endtask

	task automatic compare_flag(input bit expected, input logic actual, input string name);
		if (actual !== expected) begin
			$display("ERROR %s: expected 0x%h, got 0x%h", name, expected, actual);
			error_count++;
		end
	endtask

	function automatic data_t random_word();
		return data_t'($urandom);
	endfunction

	task automatic check_outputs();
		compare_data("data_out", exp_data, data_out);
		compare_count(count_t'(model_q.size()), use_dw);
		compare_flag(model_q.size() != 0, f_empty_n, "f_empty_n");
		compare_flag(model_q.size() != FIFO_DEPTH, f_full_n, "f_full_n");
	endtask

	// One clock with the given controls, model follows the acceptance rules
	task automatic do_cycle(input logic wr, input logic rd, input data_t din);
		int n;
		n = model_q.size();
		write   = wr;
		read    = rd;
		data_in = din;
		@(posedge CLK);
		if (n == 0) begin
			// Read alone is ignored, read with write passes the word through
			if (wr && rd) begin
				exp_data = din;
			end else if (wr) begin
				model_q.push_back(din);
			end
		end else begin
			if (rd) begin
				exp_data = model_q.pop_front();
			end
			// Full drops a write that comes without a read
			if (wr && (rd || n < FIFO_DEPTH)) begin
				model_q.push_back(din);
			end
		end
		#(DRIVE_DELAY);
		check_outputs();
	endtask

	task automatic do_clear();
		write   = 1'b0;
		read    = 1'b0;
		clear_n = 1'b0;
		@(posedge CLK);
		model_q.delete();
		#(DRIVE_DELAY);
		clear_n = 1'b1;
		check_outputs();
	endtask

	task automatic finish_test(input string name, input int errors_before);
		if (error_count == errors_before) begin
			$display("PASS %s", name);
			tests_passed++;
		end else begin
			$display("FAIL %s, %0d mismatches", name, error_count - errors_before);
			tests_failed++;
		end
	endtask

	task automatic test_reset_state();
		int start;
		start = error_count;
		check_outputs();
		do_cycle(1'b0, 1'b1, random_word());
		finish_test("reset state and read while empty", start);
	endtask

	task automatic test_write_then_read();
		int start;
		start = error_count;
		repeat (10) do_cycle(1'b1, 1'b0, random_word());
		repeat (10) do_cycle(1'b0, 1'b1, '0);
		finish_test("write then read order", start);
	endtask

	task automatic test_fill_to_full();
		int start;
		start = error_count;
		// Last write finds the FIFO full and is dropped
		repeat (FIFO_DEPTH + 1) do_cycle(1'b1, 1'b0, random_word());
		repeat (FIFO_DEPTH) do_cycle(1'b0, 1'b1, '0);
		finish_test("fill to full and drain", start);
	endtask

	task automatic test_read_write_together();
		int start;
		start = error_count;
		repeat (6) do_cycle(1'b1, 1'b0, random_word());
		repeat (4) do_cycle(1'b1, 1'b1, random_word());
		repeat (FIFO_DEPTH - 6) do_cycle(1'b1, 1'b0, random_word());
		repeat (4) do_cycle(1'b1, 1'b1, random_word());
		repeat (FIFO_DEPTH) do_cycle(1'b0, 1'b1, '0);
		finish_test("simultaneous read and write", start);
	endtask

	task automatic test_bypass();
		int start;
		start = error_count;
		repeat (3) do_cycle(1'b1, 1'b1, random_word());
		finish_test("bypass on empty", start);
	endtask

	task automatic test_clear();
		int start;
		start = error_count;
		repeat (5) do_cycle(1'b1, 1'b0, random_word());
		do_clear();
		repeat (3) do_cycle(1'b1, 1'b0, random_word());
		repeat (3) do_cycle(1'b0, 1'b1, '0);
		finish_test("synchronous clear", start);
	endtask

	initial begin
		RESET_N      = 1'b0;
		data_in      = '0;
		read         = 1'b0;
		write        = 1'b0;
		clear_n      = 1'b1;
		exp_data     = '0;
		error_count  = 0;
		tests_passed = 0;
		tests_failed = 0;
		void'($urandom(8));

		repeat (10) @(posedge CLK);
		#(DRIVE_DELAY);
		RESET_N = 1'b1;

		test_reset_state();
		test_write_then_read();
		test_fill_to_full();
		test_read_write_together();
		test_bypass();
		test_clear();

		$display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
		if (tests_failed == 0 && error_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- source/fifo_32_8.sv
`timescale 1ns/1ps

module fifo_32_8 (
	input  logic             CLK,
	input  logic             RESET_N,
	input  fifo_pkg::data_t  data_in,
	input  logic             read,
	input  logic             write,
	input  logic             clear_n,
	output fifo_pkg::data_t  data_out,
	output logic             f_full_n,
	output logic             f_empty_n,
	output fifo_pkg::count_t use_dw
);

	import fifo_pkg::*;

	// Strobes from the controller
	logic wr_en;
	logic rd_en;
	logic bypass;
	logic count_en;
	logic count_up;

	// RAM addresses from the pointer counters
	addr_t wr_addr;
	addr_t rd_addr;

	fifo_control control (
		.CLK       (CLK),
		.RESET_N   (RESET_N),
		.read      (read),
		.write     (write),
		.clear_n   (clear_n),
		.use_dw    (use_dw),
		.wr_en     (wr_en),
		.rd_en     (rd_en),
		.bypass    (bypass),
		.count_en  (count_en),
		.count_up  (count_up),
		.f_full_n  (f_full_n),
		.f_empty_n (f_empty_n)
	);

	// Write pointer, always counts up
	updown_counter #(.WIDTH(ADDR_WIDTH)) wr_ptr (
		.CLK     (CLK),
		.RESET_N (RESET_N),
		.clear_n (clear_n),
		.enable  (wr_en),
		.up      (1'b1),
		.value   (wr_addr)
	);

	// Read pointer, always counts up
	updown_counter #(.WIDTH(ADDR_WIDTH)) rd_ptr (
		.CLK     (CLK),
		.RESET_N (RESET_N),
		.clear_n (clear_n),
		.enable  (rd_en),
		.up      (1'b1),
		.value   (rd_addr)
	);

	// Number of stored words, 0 to 32
	updown_counter #(.WIDTH(COUNT_WIDTH)) occupancy (
		.CLK     (CLK),
		.RESET_N (RESET_N),
		.clear_n (clear_n),
		.enable  (count_en),
		.up      (count_up),
		.value   (use_dw)
	);

	fifo_ram ram (
		.CLK      (CLK),
		.RESET_N  (RESET_N),
		.data_in  (data_in),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.rd_en    (rd_en),
		.rd_addr  (rd_addr),
		.bypass   (bypass),
		.data_out (data_out)
	);

endmodule

//--- source/fifo_control.sv
`timescale 1ns/1ps

module fifo_control (
	input  logic             CLK,
	input  logic             RESET_N,
	input  logic             read,
	input  logic             write,
	input  logic             clear_n,
	input  fifo_pkg::count_t use_dw,
	output logic             wr_en,
	output logic             rd_en,
	output logic             bypass,
	output logic             count_en,
	output logic             count_up,
	output logic             f_full_n,
	output logic             f_empty_n
);

	import fifo_pkg::*;

	fifo_state_t state;
	fifo_state_t next_state;

	logic last_slot;
	logic last_word;

	// Count levels at which a single write fills or a single read empties
	assign last_slot = (use_dw == count_t'(FIFO_DEPTH - 1));
	assign last_word = (use_dw == count_t'(1));

	// Decode of the write/read pair per state
	always_comb begin
		wr_en      = 1'b0;
		rd_en      = 1'b0;
		bypass     = 1'b0;
		count_en   = 1'b0;
		count_up   = 1'b0;
		next_state = state;

		if (!clear_n) begin
			// Counters clear on their own, nothing moves in the datapath
			next_state = EMPTY;
		end else begin
			case (state)
				EMPTY: begin
					if (write && read) begin
						// Pass-through, RAM and counters stay untouched
						bypass = 1'b1;
					end else if (write) begin
						wr_en      = 1'b1;
						count_en   = 1'b1;
						count_up   = 1'b1;
						next_state = OTHER;
					end
				end

				OTHER: begin
					if (write && read) begin
						wr_en = 1'b1;
						rd_en = 1'b1;
					end else if (write) begin
						wr_en    = 1'b1;
						count_en = 1'b1;
						count_up = 1'b1;
						if (last_slot) begin
							next_state = FULL;
						end
					end else if (read) begin
						rd_en    = 1'b1;
						count_en = 1'b1;
						if (last_word) begin
							next_state = EMPTY;
						end
					end
				end

				FULL: begin
					// A lone write is dropped here
					if (write && read) begin
						wr_en = 1'b1;
						rd_en = 1'b1;
					end else if (read) begin
						rd_en      = 1'b1;
						count_en   = 1'b1;
						next_state = OTHER;
					end
				end

				default: begin
					next_state = EMPTY;
				end
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (!RESET_N) begin
			state <= EMPTY;
		end else begin
			state <= next_state;
		end
	end

	// Flags follow the registered state, same edge as use_dw
	assign f_empty_n = (state != EMPTY);
	assign f_full_n  = (state != FULL);

endmodule

//--- source/fifo_pkg.sv
package fifo_pkg;

	// Word and depth of the FIFO
	localparam int DATA_WIDTH  = 8;
	localparam int FIFO_DEPTH  = 32;

	// Pointer width covers 32 entries, count needs one more bit to show 32
	localparam int ADDR_WIDTH  = 5;
	localparam int COUNT_WIDTH = 6;

	typedef logic [DATA_WIDTH-1:0]  data_t;
	typedef logic [ADDR_WIDTH-1:0]  addr_t;
	typedef logic [COUNT_WIDTH-1:0] count_t;

	// Controller state
	typedef enum logic [1:0] {
		EMPTY = 2'b00,
		OTHER = 2'b01,
		FULL  = 2'b10
	} fifo_state_t;

endpackage

//--- source/fifo_ram.sv
`timescale 1ns/1ps

module fifo_ram (
	input  logic            CLK,
	input  logic            RESET_N,
	input  fifo_pkg::data_t data_in,
	input  logic            wr_en,
	input  fifo_pkg::addr_t wr_addr,
	input  logic            rd_en,
	input  fifo_pkg::addr_t rd_addr,
	input  logic            bypass,
	output fifo_pkg::data_t data_out
);

	import fifo_pkg::*;

	// Storage array, one word per entry
	data_t mem [FIFO_DEPTH];

	data_t rd_word;

	// Write port
	always_ff @(posedge CLK) begin
		if (wr_en) begin
			mem[wr_addr] <= data_in;
		end
	end

	// Old contents are seen if rd_addr equals wr_addr in this cycle
	assign rd_word = mem[rd_addr];

	// Registered read port
	// bypass selects the input word straight through, rd_en the stored head
	always_ff @(posedge CLK) begin
		if (!RESET_N) begin
			data_out <= '0;
		end else if (bypass) begin
			data_out <= data_in;
		end else if (rd_en) begin
			data_out <= rd_word;
		end
	end

endmodule

//--- source/updown_counter.sv
`timescale 1ns/1ps

module updown_counter #(
	parameter int WIDTH = 5
) (
	input  logic             CLK,
	input  logic             RESET_N,
	input  logic             clear_n,
	input  logic             enable,
	input  logic             up,
	output logic [WIDTH-1:0] value
);

	logic [WIDTH-1:0] next_value;

	// One step in either direction, wraps at the ends
	always_comb begin
		if (up) begin
			next_value = value + 1'b1;
		end else begin
			next_value = value - 1'b1;
		end
	end

	// Clear wins over a count step in the same cycle
	always_ff @(posedge CLK) begin
		if (!RESET_N) begin
			value <= '0;
		end else if (!clear_n) begin
			value <= '0;
		end else if (enable) begin
			value <= next_value;
		end
	end

endmodule
